// ==== source/isa_pkg.sv ====
`default_nettype none

package isa_pkg;
	localparam int reg_index_width = 5;
	localparam int imm14_width = 14;
	localparam int imm24_width = 24;
	localparam logic [reg_index_width-1:0] link_reg = 5'd30; // Target of jump-and-link.

	typedef enum logic [5:0] {
		opc_alu_rr = 6'h20,
		opc_jump   = 6'h24,
		opc_beq    = 6'h26,
		opc_addi   = 6'h28,
		opc_xori   = 6'h2b,
		opc_ori    = 6'h2c
	} opcode_t;

	typedef enum logic [4:0] {
		sub_add = 5'h00,
		sub_sub = 5'h01,
		sub_and = 5'h02,
		sub_xor = 5'h03,
		sub_or  = 5'h04,
		sub_sll = 5'h0c,
		sub_srl = 5'h0d
	} sub_op_base_t;

	typedef struct packed {
		logic                       form; // Zero for 32-bit forms.
		opcode_t                    opcode;
		logic [reg_index_width-1:0] rt;
		logic [reg_index_width-1:0] ra;
		logic                       spare;
		logic [imm14_width-1:0]     imm14; // rb and sub-op for register-register.
	} i14_t;

	typedef struct packed {
		logic                   form;
		opcode_t                opcode;
		logic                   link;
		logic [imm24_width-1:0] imm24;
	} j24_t;

	typedef union packed {
		i14_t i14;
		j24_t j24;
	} instr_u;
endpackage

`default_nettype wire

// ==== source/core_pkg.sv ====
`default_nettype none

package core_pkg;
	localparam int xlen = 32;
	localparam int instr_bytes = 4; // Fetch step.

	typedef enum logic [1:0] {
		pc_seq    = 2'd0,
		pc_branch = 2'd1,
		pc_jump   = 2'd2
	} pc_sel_t;

	typedef enum logic [1:0] {
		wr_none = 2'd0,
		wr_alu  = 2'd1,
		wr_link = 2'd2
	} wr_sel_t;
endpackage

`default_nettype wire

// ==== source/fetch_control.sv ====
`default_nettype none

module fetch_control (
	input  logic clock,
	input  logic reset,
	input  logic wb_ack,
	input  logic flush,
	output logic wb_cyc,
	output logic wb_stb,
	output logic fetch_valid,
	output logic pc_advance
);
	typedef enum logic [1:0] {
		idle,
		request,
		discard
	} state_t;

	state_t state;
	state_t state_next;

	always_ff @(posedge clock) begin
		if (reset)
			state <= idle;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		case (state)
			idle: state_next = request;
			request: begin
				if (wb_ack)
					state_next = idle; // Bus released for one cycle.
				else if (flush)
					state_next = discard;
			end
			discard: begin
				if (wb_ack)
					state_next = idle;
			end
			default: state_next = idle;
		endcase
	end

	assign wb_cyc = (state != idle);
	assign wb_stb = (state != idle);
	assign pc_advance = (state == request) && wb_ack;
	assign fetch_valid = pc_advance && !flush; // Word fetched past a taken branch is dropped.

	a_stb_in_cycle: assert property (@(posedge clock) disable iff (reset)
		wb_stb |-> wb_cyc);
	a_no_valid_on_discard: assert property (@(posedge clock) disable iff (reset)
		(state == discard) |-> !fetch_valid);
	a_release_after_ack: assert property (@(posedge clock) disable iff (reset)
		wb_cyc && wb_ack |=> !wb_cyc);
endmodule

`default_nettype wire

// ==== source/pc_counter.sv ====
`default_nettype none

module pc_counter (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      pc_advance,
	input  logic                      redirect,
	input  core_pkg::pc_sel_t         pc_sel,
	input  logic [core_pkg::xlen-1:0] branch_target,
	input  logic [core_pkg::xlen-1:0] jump_target,
	output logic [core_pkg::xlen-1:0] pc
);
	import core_pkg::*;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= '0;
		end else if (redirect) begin
			case (pc_sel)
				pc_branch: pc <= branch_target;
				pc_jump:   pc <= jump_target;
				default:   pc <= pc;
			endcase
		end else if (pc_advance) begin
			pc <= pc + xlen'(instr_bytes);
		end
	end
endmodule

`default_nettype wire

// ==== source/decode_unit.sv ====
`default_nettype none

module decode_unit (
	input  isa_pkg::instr_u                     instruction,
	output isa_pkg::opcode_t                    opcode,
	output isa_pkg::sub_op_base_t               sub_op_base,
	output logic [isa_pkg::imm14_width-1:0]     imm_14bit,
	output logic [isa_pkg::imm24_width-1:0]     imm_24bit,
	output logic [isa_pkg::reg_index_width-1:0] ra_index,
	output logic [isa_pkg::reg_index_width-1:0] rb_index,
	output logic [isa_pkg::reg_index_width-1:0] rt_index,
	output core_pkg::pc_sel_t                   select_pc,
	output core_pkg::wr_sel_t                   select_write_reg
);
	import isa_pkg::*;
	import core_pkg::*;

	assign opcode      = instruction.i14.opcode;
	assign sub_op_base = sub_op_base_t'(instruction.i14.imm14[$bits(sub_op_base_t)-1:0]);
	assign imm_14bit   = instruction.i14.imm14;
	assign imm_24bit   = instruction.j24.imm24;
	assign ra_index    = instruction.i14.ra;
	assign rb_index    = instruction.i14.imm14[imm14_width-1 -: reg_index_width]; // Top of imm14.
	assign rt_index    = (opcode == opc_jump) ? link_reg : instruction.i14.rt;

	always_comb begin
		case (opcode)
			opc_beq:  select_pc = pc_branch;
			opc_jump: select_pc = pc_jump;
			default:  select_pc = pc_seq;
		endcase
	end

	always_comb begin
		case (opcode)
			opc_alu_rr,
			opc_addi,
			opc_ori,
			opc_xori: select_write_reg = wr_alu;
			opc_jump: select_write_reg = instruction.j24.link ? wr_link : wr_none;
			default:  select_write_reg = wr_none;
		endcase
	end
endmodule

`default_nettype wire

// ==== source/register_file.sv ====
`default_nettype none

module register_file (
	input  logic                                clock,
	input  logic                                reset,
	input  logic [isa_pkg::reg_index_width-1:0] ra_index,
	input  logic [isa_pkg::reg_index_width-1:0] rb_index,
	input  logic [isa_pkg::reg_index_width-1:0] rt_index,
	output logic [core_pkg::xlen-1:0]           ra_data,
	output logic [core_pkg::xlen-1:0]           rb_data,
	output logic [core_pkg::xlen-1:0]           rt_data,
	input  logic                                wr_en,
	input  logic [isa_pkg::reg_index_width-1:0] wr_index,
	input  logic [core_pkg::xlen-1:0]           wr_data
);
	import isa_pkg::*;
	import core_pkg::*;

	logic [xlen-1:0] regs [1 << reg_index_width];

	function automatic logic [xlen-1:0] read_port(input logic [reg_index_width-1:0] index);
		logic [xlen-1:0] value;
		if (index == '0)
			value = '0;
		else if (wr_en && wr_index == index)
			value = wr_data; // Write-through.
		else
			value = regs[index];
		return value;
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < $size(regs); i++)
				regs[i] <= '0;
		end else if (wr_en && wr_index != '0) begin
			regs[wr_index] <= wr_data;
		end
	end

	always_comb begin
		ra_data = read_port(ra_index);
		rb_data = read_port(rb_index);
		rt_data = read_port(rt_index); // beq compare operand.
	end
endmodule

`default_nettype wire

// ==== source/regwalls.sv ====
`default_nettype none

module regwalls (
	input  logic                                clock,
	input  logic                                reset,
	input  logic                                flush,
	input  logic                                fetch_valid,
	input  isa_pkg::instr_u                     fetch_instruction,
	input  logic [core_pkg::xlen-1:0]           fetch_pc,
	output isa_pkg::instr_u                     reg1_instruction,
	input  logic [core_pkg::xlen-1:0]           ra_data,
	input  logic [core_pkg::xlen-1:0]           rb_data,
	input  logic [core_pkg::xlen-1:0]           rt_data,
	input  isa_pkg::opcode_t                    opcode,
	input  isa_pkg::sub_op_base_t               sub_op_base,
	input  logic [isa_pkg::imm14_width-1:0]     imm_14bit,
	input  logic [isa_pkg::imm24_width-1:0]     imm_24bit,
	input  core_pkg::pc_sel_t                   select_pc,
	input  core_pkg::wr_sel_t                   select_write_reg,
	input  logic [isa_pkg::reg_index_width-1:0] rt_index,
	output logic [core_pkg::xlen-1:0]           reg2_ra_data,
	output logic [core_pkg::xlen-1:0]           reg2_rb_data,
	output logic [core_pkg::xlen-1:0]           reg2_rt_data,
	output isa_pkg::opcode_t                    reg2_opcode,
	output isa_pkg::sub_op_base_t               reg2_sub_op_base,
	output logic [isa_pkg::imm14_width-1:0]     reg2_imm_14bit,
	output logic [isa_pkg::imm24_width-1:0]     reg2_imm_24bit,
	output core_pkg::pc_sel_t                   reg2_select_pc,
	output core_pkg::wr_sel_t                   reg2_select_write_reg,
	output logic [isa_pkg::reg_index_width-1:0] reg2_rt_index,
	output logic [core_pkg::xlen-1:0]           reg2_pc,
	output logic                                reg2_valid
);
	import core_pkg::*;

	logic [xlen-1:0] reg1_pc;
	logic            reg1_valid;

	always_ff @(posedge clock) begin
		if (fetch_valid) begin
			reg1_instruction <= fetch_instruction;
			reg1_pc          <= fetch_pc;
		end
	end

	always_ff @(posedge clock) begin
		reg2_ra_data          <= ra_data;
		reg2_rb_data          <= rb_data;
		reg2_rt_data          <= rt_data;
		reg2_opcode           <= opcode;
		reg2_sub_op_base      <= sub_op_base;
		reg2_imm_14bit        <= imm_14bit;
		reg2_imm_24bit        <= imm_24bit;
		reg2_select_pc        <= select_pc;
		reg2_select_write_reg <= select_write_reg;
		reg2_rt_index         <= rt_index;
		reg2_pc               <= reg1_pc;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			reg1_valid <= 1'b0;
			reg2_valid <= 1'b0;
		end else begin
			reg1_valid <= fetch_valid && !flush; // Empty unless a word arrived.
			reg2_valid <= reg1_valid && !flush; // Bubble when stage 1 is empty.
		end
	end

	a_flush_kills_stage2: assert property (@(posedge clock) disable iff (reset)
		flush |=> !reg2_valid);
endmodule

`default_nettype wire

// ==== source/execute_unit.sv ====
`default_nettype none

module execute_unit (
	input  logic                                valid,
	input  isa_pkg::opcode_t                    opcode,
	input  isa_pkg::sub_op_base_t               sub_op_base,
	input  logic [isa_pkg::imm14_width-1:0]     imm_14bit,
	input  logic [isa_pkg::imm24_width-1:0]     imm_24bit,
	input  logic [core_pkg::xlen-1:0]           ra_data,
	input  logic [core_pkg::xlen-1:0]           rb_data,
	input  logic [core_pkg::xlen-1:0]           rt_data,
	input  logic [isa_pkg::reg_index_width-1:0] rt_index,
	input  logic [core_pkg::xlen-1:0]           pc,
	input  core_pkg::pc_sel_t                   select_pc,
	input  core_pkg::wr_sel_t                   select_write_reg,
	output logic                                redirect,
	output core_pkg::pc_sel_t                   pc_sel,
	output logic [core_pkg::xlen-1:0]           branch_target,
	output logic [core_pkg::xlen-1:0]           jump_target,
	output logic                                wr_en,
	output logic [isa_pkg::reg_index_width-1:0] wr_index,
	output logic [core_pkg::xlen-1:0]           wr_data
);
	import isa_pkg::*;
	import core_pkg::*;

	logic [xlen-1:0]         imm_sext;
	logic [xlen-1:0]         imm_zext;
	logic [xlen-1:0]         alu_result;
	logic [$clog2(xlen)-1:0] shamt;
	logic                    taken;

	assign imm_sext = {{(xlen-imm14_width){imm_14bit[imm14_width-1]}}, imm_14bit};
	assign imm_zext = {{(xlen-imm14_width){1'b0}}, imm_14bit};
	assign shamt = rb_data[$clog2(xlen)-1:0];

	always_comb begin
		alu_result = '0;
		case (opcode)
			opc_alu_rr: begin
				case (sub_op_base)
					sub_add: alu_result = ra_data + rb_data;
					sub_sub: alu_result = ra_data - rb_data;
					sub_and: alu_result = ra_data & rb_data;
					sub_or:  alu_result = ra_data | rb_data;
					sub_xor: alu_result = ra_data ^ rb_data;
					sub_sll: alu_result = ra_data << shamt;
					sub_srl: alu_result = ra_data >> shamt;
					default: alu_result = '0;
				endcase
			end
			opc_addi: alu_result = ra_data + imm_sext;
			opc_ori:  alu_result = ra_data | imm_zext;
			opc_xori: alu_result = ra_data ^ imm_zext;
			default:  alu_result = '0;
		endcase
	end

	// Offsets count halfwords.
	assign branch_target = pc + {imm_sext[xlen-2:0], 1'b0};
	assign jump_target = pc + {{(xlen-imm24_width-1){imm_24bit[imm24_width-1]}}, imm_24bit, 1'b0};

	assign taken = (select_pc == pc_jump) || (select_pc == pc_branch && ra_data == rt_data);
	assign redirect = valid && taken;
	assign pc_sel = select_pc;

	assign wr_en = valid && (select_write_reg != wr_none) && (rt_index != '0);
	assign wr_index = rt_index;
	assign wr_data = (select_write_reg == wr_link) ? pc + xlen'(instr_bytes) : alu_result;
endmodule

`default_nettype wire

// ==== source/core_top.sv ====
`default_nettype none

module core_top (
	input  logic                                clock,
	input  logic                                reset,
	output logic                                wb_cyc,
	output logic                                wb_stb,
	output logic [core_pkg::xlen-1:0]           wb_adr,
	input  logic                                wb_ack,
	input  logic [core_pkg::xlen-1:0]           wb_dat_rd,
	output logic                                wr_en,
	output logic [isa_pkg::reg_index_width-1:0] wr_index,
	output logic [core_pkg::xlen-1:0]           wr_data
);
	import isa_pkg::*;
	import core_pkg::*;

	logic                       fetch_valid;
	logic                       pc_advance;
	logic                       redirect; // Also the pipeline flush.
	pc_sel_t                    pc_sel;
	logic [xlen-1:0]            branch_target;
	logic [xlen-1:0]            jump_target;
	instr_u                     reg1_instruction;
	opcode_t                    opcode;
	sub_op_base_t               sub_op_base;
	logic [imm14_width-1:0]     imm_14bit;
	logic [imm24_width-1:0]     imm_24bit;
	logic [reg_index_width-1:0] ra_index;
	logic [reg_index_width-1:0] rb_index;
	logic [reg_index_width-1:0] rt_index;
	pc_sel_t                    select_pc;
	wr_sel_t                    select_write_reg;
	logic [xlen-1:0]            ra_data;
	logic [xlen-1:0]            rb_data;
	logic [xlen-1:0]            rt_data;
	logic [xlen-1:0]            reg2_ra_data;
	logic [xlen-1:0]            reg2_rb_data;
	logic [xlen-1:0]            reg2_rt_data;
	opcode_t                    reg2_opcode;
	sub_op_base_t               reg2_sub_op_base;
	logic [imm14_width-1:0]     reg2_imm_14bit;
	logic [imm24_width-1:0]     reg2_imm_24bit;
	pc_sel_t                    reg2_select_pc;
	wr_sel_t                    reg2_select_write_reg;
	logic [reg_index_width-1:0] reg2_rt_index;
	logic [xlen-1:0]            reg2_pc;
	logic                       reg2_valid;

	fetch_control u_fetch_control (
		.flush(redirect),
		.*
	);

	pc_counter u_pc_counter (
		.pc(wb_adr),
		.*
	);

	decode_unit u_decode_unit (
		.instruction(reg1_instruction),
		.*
	);

	register_file u_register_file (.*);

	regwalls u_regwalls (
		.flush(redirect),
		.fetch_instruction(wb_dat_rd),
		.fetch_pc(wb_adr),
		.*
	);

	execute_unit u_execute_unit (
		.valid(reg2_valid),
		.opcode(reg2_opcode),
		.sub_op_base(reg2_sub_op_base),
		.imm_14bit(reg2_imm_14bit),
		.imm_24bit(reg2_imm_24bit),
		.ra_data(reg2_ra_data),
		.rb_data(reg2_rb_data),
		.rt_data(reg2_rt_data),
		.rt_index(reg2_rt_index),
		.pc(reg2_pc),
		.select_pc(reg2_select_pc),
		.select_write_reg(reg2_select_write_reg),
		.*
	);
endmodule

`default_nettype wire

// ==== verif/core_tb.sv ====
`default_nettype none

module core_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import isa_pkg::*;
	import core_pkg::*;

	localparam int clock_period = 10;
	localparam int reset_cycles = 16;
	localparam int drain_cycles = 20;
	localparam int worst_fetch_cycles = 5; // Idle, request and three wait states.
	localparam int mem_words = 256;
	localparam int prog_len = 96;
	localparam logic [31:0] lfsr_seed = 32'hd6a4c987;

	logic                       clock = 1'b0;
	logic                       reset;
	logic                       wb_cyc;
	logic                       wb_stb;
	logic [xlen-1:0]            wb_adr;
	logic                       wb_ack;
	logic [xlen-1:0]            wb_dat_rd;
	logic                       wr_en;
	logic [reg_index_width-1:0] wr_index;
	logic [xlen-1:0]            wr_data;

	logic [31:0] program_mem [mem_words];
	logic [31:0] lfsr_state;
	logic [4:0]  exp_wr_index [$];
	logic [31:0] exp_wr_data [$];
	logic [31:0] exp_starts [$]; // Address of every bus request, wrong path included.
	int          write_idx;
	int          start_idx;
	logic        prev_cyc;
	logic        pending;
	logic [1:0]  waits_left;
	logic        model_ready;

	core_top uut (
		.clock(clock),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_adr(wb_adr),
		.wb_ack(wb_ack),
		.wb_dat_rd(wb_dat_rd),
		.wr_en(wr_en),
		.wr_index(wr_index),
		.wr_data(wr_data)
	);

	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		logic        out_bit;
		value = '0;
		for (int i = 0; i < count; i++) begin
			out_bit = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (out_bit)
				lfsr_state = lfsr_state ^ 32'h80200003;
			value = {value[30:0], out_bit};
		end
		return value;
	endfunction

	// Small register set so that operands collide often.
	function automatic logic [4:0] pick_reg();
		logic [2:0] sel;
		sel = 3'(random_bits(3));
		return (sel == 3'd7) ? 5'd30 : {2'b00, sel};
	endfunction

	function automatic logic [4:0] pick_sub_op();
		logic [2:0] sel;
		sel = 3'(random_bits(3));
		case (sel)
			3'd1: return sub_sub;
			3'd2: return sub_and;
			3'd3: return sub_xor;
			3'd4: return sub_or;
			3'd5: return sub_sll;
			3'd6: return sub_srl;
			default: return sub_add;
		endcase
	endfunction

	function automatic logic [31:0] encode_i14(input opcode_t op, input logic [4:0] rt,
			input logic [4:0] ra, input logic [13:0] imm);
		return {1'b0, op, rt, ra, 1'b0, imm};
	endfunction

	function automatic logic [31:0] encode_j24(input logic link, input logic [23:0] imm);
		return {1'b0, opc_jump, link, imm};
	endfunction

	function automatic void build_program();
		logic [2:0]  kind;
		logic [4:0]  rt;
		logic [4:0]  ra;
		logic [4:0]  rb;
		logic [13:0] imm;
		int          target;
		for (int i = 0; i < mem_words; i++)
			program_mem[i] = 32'ha5000000 | 32'(i * 4);
		for (int i = 0; i < prog_len - 1; i++) begin
			kind = 3'(random_bits(3));
			rt = pick_reg();
			ra = pick_reg();
			rb = pick_reg();
			imm = 14'(random_bits(14));
			target = i + 1 + int'(random_bits(3)); // Forward only, so every path ends.
			if (target > prog_len - 1)
				target = prog_len - 1;
			case (kind)
				3'd3: program_mem[i] = encode_i14(opc_addi, rt, ra, imm);
				3'd4: program_mem[i] = encode_i14(opc_ori, rt, ra, imm);
				3'd5: program_mem[i] = encode_i14(opc_xori, rt, ra, imm);
				3'd6: begin
					if (random_bits(1) == 32'd1)
						ra = rt; // Always taken.
					program_mem[i] = encode_i14(opc_beq, rt, ra, 14'((target - i) * 2));
				end
				3'd7: program_mem[i] = encode_j24(1'(random_bits(1)), 24'((target - i) * 2));
				default: program_mem[i] = encode_i14(opc_alu_rr, rt, ra,
					{rb, 4'b0000, pick_sub_op()});
			endcase
		end
		program_mem[prog_len - 1] = encode_j24(1'b0, 24'd0); // Final self-jump.
	endfunction

	// ISA model of the program, from pc 0 to the self-jump.
	function automatic void run_reference();
		logic [31:0] regs [32];
		logic [31:0] pc;
		logic [31:0] word;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] result;
		logic [31:0] next_pc;
		logic [4:0]  dest;
		logic [4:0]  sub;
		logic        write;
		logic        taken;
		logic        done;
		opcode_t     op;
		int          steps;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		pc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 4 * prog_len) begin
			word = program_mem[pc[9:2]];
			op = opcode_t'(word[30:25]);
			sub = word[4:0];
			a = regs[word[19:15]];
			b = regs[word[13:9]];
			dest = word[24:20];
			write = 1'b0;
			taken = 1'b0;
			result = '0;
			next_pc = pc + 32'd4;
			case (op)
				opc_alu_rr: begin
					write = 1'b1;
					case (sub)
						sub_add: result = a + b;
						sub_sub: result = a - b;
						sub_and: result = a & b;
						sub_or:  result = a | b;
						sub_xor: result = a ^ b;
						sub_sll: result = a << b[4:0];
						sub_srl: result = a >> b[4:0];
						default: result = '0;
					endcase
				end
				opc_addi: begin
					write = 1'b1;
					result = a + 32'($signed(word[13:0]));
				end
				opc_ori: begin
					write = 1'b1;
					result = a | {18'd0, word[13:0]};
				end
				opc_xori: begin
					write = 1'b1;
					result = a ^ {18'd0, word[13:0]};
				end
				opc_beq: begin
					taken = (a == regs[word[24:20]]);
					if (taken)
						next_pc = pc + (32'($signed(word[13:0])) << 1);
				end
				opc_jump: begin
					taken = 1'b1;
					next_pc = pc + (32'($signed(word[23:0])) << 1);
					write = word[24];
					dest = 5'd30;
					result = pc + 32'd4;
					done = (next_pc == pc);
				end
				default: write = 1'b0;
			endcase
			exp_starts.push_back(pc);
			if (taken)
				exp_starts.push_back(pc + 32'd4); // Fetch in flight, then dropped.
			if (write && dest != 5'd0) begin
				regs[dest] = result;
				exp_wr_index.push_back(dest);
				exp_wr_data.push_back(result);
			end
			pc = next_pc;
			steps++;
		end
	endfunction

	task automatic stop_on_mismatch(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("** Error at %0d ns: %s expected %h, got %h", $time, what, expected, actual);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic stop_with_reason(input string reason);
		$display("Failure at %0d ns: %s", $time, reason);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	initial begin
		forever #(clock_period / 2) clock = ~clock;
	end

	// Wishbone slave with random wait states.
	always @(negedge clock) begin
		if (reset) begin
			wb_ack <= 1'b0;
			pending = 1'b0;
		end else if (wb_ack) begin
			wb_ack <= 1'b0; // Transfer ended on the last rising edge.
			pending = 1'b0;
		end else if (wb_cyc && wb_stb) begin
			if (!pending) begin
				pending = 1'b1;
				waits_left = 2'(random_bits(2));
			end
			if (waits_left == 2'd0) begin
				wb_ack <= 1'b1;
				wb_dat_rd <= program_mem[wb_adr[9:2]];
			end else begin
				waits_left = waits_left - 2'd1;
			end
		end
	end

	always @(negedge clock) begin
		if (reset) begin
			assert (!wb_cyc && !wb_stb && !wr_en)
			else stop_on_mismatch("cyc, stb and wr_en in reset", 32'd0,
				{29'd0, wb_cyc, wb_stb, wr_en});
		end else begin
			if (wb_cyc && !prev_cyc && start_idx < exp_starts.size()) begin
				assert (wb_adr == exp_starts[start_idx])
				else stop_on_mismatch("request address", exp_starts[start_idx], wb_adr);
				start_idx++;
			end
			if (wr_en) begin
				assert (write_idx < exp_wr_index.size())
				else stop_with_reason("register write after the expected sequence ended");
				assert (wr_index == exp_wr_index[write_idx])
				else stop_on_mismatch("write index", 32'(exp_wr_index[write_idx]),
					32'(wr_index));
				assert (wr_data == exp_wr_data[write_idx])
				else stop_on_mismatch("write data", exp_wr_data[write_idx], wr_data);
				write_idx++;
			end
		end
		prev_cyc = wb_cyc;
	end

	initial begin : watchdog
		int limit_ns;
		wait (model_ready);
		limit_ns = 2 * clock_period * (reset_cycles + drain_cycles
			+ worst_fetch_cycles * exp_starts.size());
		#(limit_ns);
		$display("Timeout at %0d ns: the core did not reach the end of the program", $time);
		$display("ERRORS FOUND");
		$fatal(1);
	end

	initial begin
		reset = 1'b1;
		wb_ack = 1'b0;
		wb_dat_rd = '0;
		write_idx = 0;
		start_idx = 0;
		prev_cyc = 1'b0;
		pending = 1'b0;
		waits_left = 2'd0;
		model_ready = 1'b0;
		lfsr_state = lfsr_seed;
		build_program();
		run_reference();
		model_ready = 1'b1;
		repeat (reset_cycles) @(negedge clock);
		reset <= 1'b0;
		while (write_idx < exp_wr_index.size() || start_idx < exp_starts.size())
			@(negedge clock);
		repeat (drain_cycles) @(negedge clock); // Self-jump loop must stay silent.
		$display("NO ERRORS");
		$finish;
	end
endmodule

`default_nettype wire

// ==== build.f ====
source/isa_pkg.sv
source/core_pkg.sv
source/fetch_control.sv
source/pc_counter.sv
source/decode_unit.sv
source/register_file.sv
source/regwalls.sv
source/execute_unit.sv
source/core_top.sv
verif/core_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module core_tb \
		-Mdir obj_dir -o core_sim
	./obj_dir/core_sim | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log
